/* verilog/rv_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction set view of the decode stage: micro-ops, major opcodes
// and the one-hot subset masks a pipe uses to declare what it runs
// import into any block that decodes or routes micro-ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_isa_pkg;

  localparam int num_uops = 7;            // legal micro-ops, one subset bit each

  // micro-op handed to the execution pipes, op_illegal marks a dropped word
  typedef enum logic [3:0] {
    op_add,
    op_mul,
    op_lw,
    op_sw,
    op_jal,
    op_jalr,
    op_beq,
    op_illegal
  } rv_uop;

  // major opcode field, bits 6:0 of the instruction word
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,              // register-register arithmetic, add and mul
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011
  } rv_opcode;

  // bit n is set when micro-op n of rv_uop is supported
  typedef logic [num_uops-1:0] rv_subset;

  localparam rv_subset op_add_vec  = 7'b0000001;
  localparam rv_subset op_mul_vec  = 7'b0000010;
  localparam rv_subset op_lw_vec   = 7'b0000100;
  localparam rv_subset op_sw_vec   = 7'b0001000;
  localparam rv_subset op_jal_vec  = 7'b0010000;
  localparam rv_subset op_jalr_vec = 7'b0100000;
  localparam rv_subset op_beq_vec  = 7'b1000000;

endpackage

/* verilog/decode_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// microarchitecture defaults for the decode stage
// the top level takes its pipe count and pipe masks from here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package decode_cfg_pkg;

  import rv_isa_pkg::*;

  localparam int xlen           = 32;     // data and immediate width
  localparam int num_pipes_dflt = 3;

  // pipe 0 is the alu and branch pipe
  localparam rv_subset pipe0_subset = op_add_vec | op_jal_vec | op_jalr_vec | op_beq_vec;
  // pipe 1 owns the multiplier but also takes spill-over adds
  localparam rv_subset pipe1_subset = op_add_vec | op_mul_vec;
  // pipe 2 is the memory pipe
  localparam rv_subset pipe2_subset = op_lw_vec | op_sw_vec;

  // element 0 sits at the low end, so pipe 0 is the rightmost entry
  localparam rv_subset [num_pipes_dflt-1:0] pipe_subsets_dflt = {
    pipe2_subset,
    pipe1_subset,
    pipe0_subset
  };

endpackage

/* verilog/inst_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational decoder for the supported rv32 instructions
// turns one word into a micro-op, register fields and an immediate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module inst_decoder
  import rv_isa_pkg::*;
  import decode_cfg_pkg::*;
(
  input  logic [31:0]     inst,
  output rv_uop           uop,
  output logic [4:0]      rd,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [xlen-1:0] imm
);

  rv_opcode        opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;

  assign opcode = rv_opcode'(inst[6:0]);  // unknown encodings fall to the default arm
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields sit at fixed positions in every format
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // all immediates sign-extend from bit 31
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    uop = op_illegal;                     // anything not matched below is dropped later
    case (opcode)
      opc_op: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) uop = op_add;
        if (funct3 == 3'b000 && funct7 == 7'b0000001) uop = op_mul;   // m extension
      end
      opc_load: begin
        if (funct3 == 3'b010) uop = op_lw;                            // word loads only
      end
      opc_store: begin
        if (funct3 == 3'b010) uop = op_sw;
      end
      opc_jal: uop = op_jal;              // no funct3 in the j format
      opc_jalr: begin
        if (funct3 == 3'b000) uop = op_jalr;
      end
      opc_branch: begin
        if (funct3 == 3'b000) uop = op_beq;
      end
      default: uop = op_illegal;
    endcase
  end

  // immediate is picked by the decoded micro-op, so an illegal word carries zero
  always_comb begin
    case (uop)
      op_lw, op_jalr: imm = imm_i;
      op_sw:          imm = imm_s;
      op_beq:         imm = imm_b;
      op_jal:         imm = imm_j;
      default:        imm = '0;
    endcase
  end

endmodule

/* verilog/inst_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// priority router from the decode register to the execution pipes
// the lowest ready pipe whose subset holds the micro-op takes it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module inst_router_unit
  import rv_isa_pkg::*;
#(
  parameter rv_subset p_isa_subset = op_add_vec
) (
  input  rv_uop uop,
  input  logic  already_found,            // a lower pipe takes this micro-op now
  input  logic  rdy,
  output logic  val,
  output logic  been_found,
  output logic  supports
);

  rv_subset uop_vec;

  always_comb begin
    case (uop)                            // one-hot view of the micro-op
      op_add:  uop_vec = op_add_vec;
      op_mul:  uop_vec = op_mul_vec;
      op_lw:   uop_vec = op_lw_vec;
      op_sw:   uop_vec = op_sw_vec;
      op_jal:  uop_vec = op_jal_vec;
      op_jalr: uop_vec = op_jalr_vec;
      op_beq:  uop_vec = op_beq_vec;
      default: uop_vec = '0;              // op_illegal matches no pipe
    endcase
  end

  assign supports   = |(uop_vec & p_isa_subset);
  assign val        = supports & ~already_found;        // own rdy stays out of val
  assign been_found = (supports & rdy) | already_found; // pass the claim up the chain

endmodule

module inst_router
  import rv_isa_pkg::*;
  import decode_cfg_pkg::*;
#(
  parameter int                          p_num_pipes    = num_pipes_dflt,
  parameter rv_subset [p_num_pipes-1:0]  p_pipe_subsets = pipe_subsets_dflt
) (
  input  rv_uop                  uop,
  input  logic [p_num_pipes-1:0] ex_rdy,
  output logic [p_num_pipes-1:0] ex_val,
  output logic                   routed,      // some pipe takes the micro-op this cycle
  output logic                   unsupported  // no configured pipe can run it
);

  logic [p_num_pipes:0]   found;
  logic [p_num_pipes-1:0] supports;

  assign found[0] = 1'b0;                 // nothing claimed below pipe 0

  for (genvar i = 0; i < p_num_pipes; i++) begin : g_unit
    inst_router_unit #(
      .p_isa_subset (p_pipe_subsets[i])
    ) inst_router_unit_i (
      .uop           (uop),
      .already_found (found[i]),
      .rdy           (ex_rdy[i]),
      .val           (ex_val[i]),
      .been_found    (found[i+1]),
      .supports      (supports[i])
    );
  end

  assign routed      = found[p_num_pipes];
  assign unsupported = ~|supports;

  // the chain must hand each micro-op to a single pipe
  always_comb begin
    assert #0 ($onehot0(ex_val & ex_rdy))
      else $error("router transfers on several pipes at once, val %b rdy %b", ex_val, ex_rdy);
  end

endmodule

/* verilog/decode_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage top level, one word per cycle from fetch
// holds the word, decodes it and steers it to an execution pipe
// dropped words raise illegal for one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_unit
  import rv_isa_pkg::*;
  import decode_cfg_pkg::*;
#(
  parameter int                          p_num_pipes    = num_pipes_dflt,
  parameter rv_subset [p_num_pipes-1:0]  p_pipe_subsets = pipe_subsets_dflt
) (
  input  logic                   clk,
  input  logic                   rst,

  // fetch side
  input  logic                   in_val,
  output logic                   in_rdy,
  input  logic [31:0]            in_inst,

  // execution pipes, payload is broadcast to all of them
  output logic [p_num_pipes-1:0] ex_val,
  input  logic [p_num_pipes-1:0] ex_rdy,
  output rv_uop                  ex_uop,
  output logic [4:0]             ex_rd,
  output logic [4:0]             ex_rs1,
  output logic [4:0]             ex_rs2,
  output logic [xlen-1:0]        ex_imm,

  output logic                   illegal
);

  logic        valid_q;                   // decode register holds a word
  logic [31:0] inst_q;
  rv_uop       dec_uop;
  rv_uop       route_uop;
  logic        routed;
  logic        unsupported;
  logic        leave;

  inst_decoder inst_decoder_i (
    .inst (inst_q),
    .uop  (dec_uop),
    .rd   (ex_rd),
    .rs1  (ex_rs1),
    .rs2  (ex_rs2),
    .imm  (ex_imm)
  );

  // an empty register looks like an illegal op, which no pipe claims
  assign route_uop = valid_q ? dec_uop : op_illegal;

  inst_router #(
    .p_num_pipes    (p_num_pipes),
    .p_pipe_subsets (p_pipe_subsets)
  ) inst_router_i (
    .uop         (route_uop),
    .ex_rdy      (ex_rdy),
    .ex_val      (ex_val),
    .routed      (routed),
    .unsupported (unsupported)
  );

  assign ex_uop  = dec_uop;
  assign illegal = valid_q & unsupported;           // only for the one cycle it sits here
  assign leave   = valid_q & (routed | unsupported); // taken by a pipe or dropped
  assign in_rdy  = ~valid_q | leave;                 // refill in the same cycle it empties

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_rdy) begin
      valid_q <= in_val;                  // clears when fetch has nothing to give
    end
  end

  always_ff @(posedge clk) begin
    if (in_rdy && in_val) begin
      inst_q <= in_inst;                  // payload needs no reset, valid_q guards it
    end
  end

  // a word that has not left must stay put until a pipe takes it
  a_hold_word: assert property (
    @(posedge clk) disable iff (rst)
    (valid_q && !leave) |=> (valid_q && $stable(inst_q))
  ) else $error("decode register changed before its word left");

endmodule

/* tb/decode_unit_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the decode stage, directed tests and a random stream
// a cycle model predicts every pipe transfer and illegal pulse
// a second instance runs without a multiplier pipe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decode_unit_tb
  import rv_isa_pkg::*;
();

  typedef logic [54:0] rec_t;             // pipe, uop, rd, rs1, rs2, imm

  localparam rec_t ill_rec = {4'hf, 51'd0};
  localparam rv_subset alu_br_vec = op_add_vec | op_jal_vec | op_jalr_vec | op_beq_vec;
  localparam rv_subset [2:0] main_subsets  = {op_lw_vec | op_sw_vec, op_add_vec | op_mul_vec,
                                              alu_br_vec};
  localparam rv_subset [2:0] nomul_subsets = {op_lw_vec | op_sw_vec, op_add_vec, alu_br_vec};
  // rough cycles per test: reset, decode, fallback, back-pressure, illegal, random
  localparam int test_cycles = 10 + 40 + 40 + 30 + 40 + 1000;

  logic        clk;
  logic        rst;
  logic        in_val;
  logic        in_rdy;
  logic [31:0] in_inst;
  rec_t        in_exp;                    // what the model expects of the offered word
  logic [2:0]  ex_val;
  logic [2:0]  ex_rdy;
  rv_uop       ex_uop;
  logic [4:0]  ex_rd;
  logic [4:0]  ex_rs1;
  logic [4:0]  ex_rs2;
  logic [31:0] ex_imm;
  logic        illegal;
  logic        nm_in_val;
  logic        nm_in_rdy;
  logic [31:0] nm_in_inst;
  logic [2:0]  nm_ex_val;
  logic [2:0]  nm_ex_rdy;
  rv_uop       nm_ex_uop;
  logic        nm_illegal;

  rec_t        exp_q[$];
  rec_t        act_q[$];
  logic        mdl_valid;
  rec_t        mdl_rec;
  int          err_cnt;
  int          test_cnt;
  int          test_err0;
  int          nm_ill_cnt;
  int          nm_xfer_cnt;
  rv_uop       nm_last_uop;
  int          seed = 30446;
  string       cur_test;

  decode_unit decode_unit_i (
    .clk (clk), .rst (rst), .in_val (in_val), .in_rdy (in_rdy), .in_inst (in_inst),
    .ex_val (ex_val), .ex_rdy (ex_rdy), .ex_uop (ex_uop), .ex_rd (ex_rd), .ex_rs1 (ex_rs1),
    .ex_rs2 (ex_rs2), .ex_imm (ex_imm), .illegal (illegal)
  );

  decode_unit #(
    .p_num_pipes    (3),
    .p_pipe_subsets (nomul_subsets)
  ) decode_unit_nomul_i (
    .clk (clk), .rst (rst), .in_val (nm_in_val), .in_rdy (nm_in_rdy), .in_inst (nm_in_inst),
    .ex_val (nm_ex_val), .ex_rdy (nm_ex_rdy), .ex_uop (nm_ex_uop), .ex_rd (), .ex_rs1 (),
    .ex_rs2 (), .ex_imm (), .illegal (nm_illegal)
  );

  always #5 clk = ~clk;

  function automatic rv_subset uop_bit(input rv_uop u);
    if (u == op_illegal) return '0;
    return rv_subset'(1) << int'(u);      // bit n stands for micro-op n
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("mismatch in %s: %s expected %h actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  // random word for micro-op u, sign sets the sign of its immediate
  task automatic build(input rv_uop u, input logic sign, output logic [31:0] w,
                       output rec_t e);
    logic [31:0] raw;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    raw     = $random(seed);
    rd      = 5'($random(seed));
    rs1     = 5'($random(seed));
    rs2     = 5'($random(seed));
    raw[20] = sign;                       // sign bit of the j-type value
    raw[12] = sign;                       // and of the b-type value
    raw[11] = sign;                       // and of the i- and s-type values
    case (u)
      op_add:  w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      op_mul:  w = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
      op_lw:   w = {raw[11:0], rs1, 3'b010, rd, 7'b0000011};
      op_sw:   w = {raw[11:5], rs2, rs1, 3'b010, raw[4:0], 7'b0100011};
      op_jal:  w = {raw[20], raw[10:1], raw[11], raw[19:12], rd, 7'b1101111};
      op_jalr: w = {raw[11:0], rs1, 3'b000, rd, 7'b1100111};
      op_beq:  w = {raw[12], raw[10:5], rs2, rs1, 3'b000, raw[4:1], raw[11], 7'b1100011};
      default: w = {raw[31:7], 7'b0010011};   // op-imm lies outside the supported set
    endcase
    case (u)
      op_lw, op_sw, op_jalr: imm = {{20{raw[11]}}, raw[11:0]};
      op_beq:  imm = {{19{raw[12]}}, raw[12:1], 1'b0};
      op_jal:  imm = {{11{raw[20]}}, raw[20:1], 1'b0};
      default: imm = '0;
    endcase
    e = {4'h0, u, w[11:7], w[19:15], w[24:20], imm};  // pipe is filled in by the model
  endtask

  // cycle model of the decode register and the priority chain
  always @(posedge clk) begin : ref_model
    logic [2:0] sup;
    logic [2:0] xval;
    logic       found;
    logic       leave;
    if (rst) begin
      mdl_valid = 1'b0;
    end else begin
      found = 1'b0;
      for (int i = 0; i < 3; i++) begin
        sup[i]  = mdl_valid && |(uop_bit(rv_uop'(mdl_rec[50:47])) & main_subsets[i]);
        xval[i] = sup[i] && !found;       // hidden once a lower pipe takes it
        if (xval[i] && ex_rdy[i]) begin
          found = 1'b1;
          exp_q.push_back({4'(i), mdl_rec[50:0]});
        end
      end
      if (mdl_valid && sup == 3'b000) exp_q.push_back(ill_rec);
      leave = mdl_valid && (found || sup == 3'b000);
      check("ex_val", 64'(xval), 64'(ex_val));
      check("illegal", 64'(mdl_valid && sup == 3'b000), 64'(illegal));
      check("in_rdy", 64'(!mdl_valid || leave), 64'(in_rdy));
      if (!mdl_valid || leave) begin
        mdl_valid = in_val;
        mdl_rec   = in_exp;
      end
    end
  end

  // records what the DUT really hands out, in edge order
  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 3; i++) begin
        if (ex_val[i] && ex_rdy[i]) begin
          act_q.push_back({4'(i), ex_uop, ex_rd, ex_rs1, ex_rs2, ex_imm});
        end
      end
      if (illegal) act_q.push_back(ill_rec);
      if (nm_illegal) nm_ill_cnt++;
      if (|(nm_ex_val & nm_ex_rdy)) begin
        nm_xfer_cnt++;
        nm_last_uop = nm_ex_uop;
      end
    end
  end

  task automatic offer(input logic [31:0] w, input rec_t e);
    in_val  <= 1'b1;
    in_inst <= w;
    in_exp  <= e;
  endtask

  // waits for the fetch handshake and drops in_val on that edge
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!in_rdy && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!in_rdy) begin
      $display("error in %s: fetch handshake never completed", cur_test);
      err_cnt++;
    end
    @(posedge clk);
    in_val <= 1'b0;
  endtask

  task automatic send(input rv_uop u, input logic sign);
    logic [31:0] w;
    rec_t        e;
    build(u, sign, w, e);
    offer(w, e);
    wait_accept();
  endtask

  task automatic nm_send(input rv_uop u);
    logic [31:0] w;
    rec_t        e;
    int          n;
    build(u, 1'b0, w, e);
    nm_in_val  <= 1'b1;
    nm_in_inst <= w;
    n = 0;
    @(negedge clk);
    while (!nm_in_rdy && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!nm_in_rdy) begin
      $display("error in %s: fetch handshake of the nomul instance never completed", cur_test);
      err_cnt++;
    end
    @(posedge clk);
    nm_in_val <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    while (mdl_valid && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (mdl_valid) begin
      $display("error in %s: decode register never emptied", cur_test);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    drain();
    check("event count", 64'(exp_q.size()), 64'(act_q.size()));
    while (exp_q.size() > 0 && act_q.size() > 0) begin
      check("event", 64'(exp_q.pop_front()), 64'(act_q.pop_front()));
    end
    exp_q.delete();
    act_q.delete();
    $display("test %s finished with %0d errors", cur_test, err_cnt - test_err0);
    @(posedge clk);
  endtask

  task automatic test_reset();
    start_test("reset");
    @(negedge clk);
    check("ex_val", 64'(3'b000), 64'(ex_val));
    check("illegal", 64'(1'b0), 64'(illegal));
    check("in_rdy", 64'(1'b1), 64'(in_rdy));
    end_test();
  endtask

  task automatic test_decode();
    start_test("decode");
    ex_rdy <= 3'b111;
    for (int s = 0; s < 2; s++) begin     // second pass uses negative immediates
      for (int u = 0; u < 7; u++) send(rv_uop'(u), 1'(s));
    end
    drain();
    check("add pipe", 64'(0), 64'(act_q[0][54:51]));
    end_test();
  endtask

  task automatic test_fallback();
    start_test("fallback");
    ex_rdy <= 3'b110;                     // add must fall through to pipe 1
    send(op_add, 1'b0);
    drain();
    @(posedge clk);
    ex_rdy <= 3'b101;
    send(op_mul, 1'b0);
    repeat (5) @(negedge clk);
    check("transfers while mul waits", 64'(1), 64'(act_q.size()));
    @(posedge clk);
    ex_rdy <= 3'b111;
    drain();
    check("add pipe", 64'(1), 64'(act_q[0][54:51]));
    check("mul pipe and uop", 64'({4'd1, op_mul}), 64'(act_q[1][54:47]));
    end_test();
  endtask

  task automatic test_backpressure();
    logic [31:0] w;
    rec_t        e;
    start_test("backpressure");
    ex_rdy <= 3'b011;
    send(op_lw, 1'b1);
    build(op_add, 1'b0, w, e);
    offer(w, e);
    repeat (5) begin
      @(negedge clk);
      check("in_rdy held", 64'(1'b0), 64'(in_rdy));
    end
    @(posedge clk);
    ex_rdy <= 3'b111;
    wait_accept();
    drain();
    check("first uop", 64'(op_lw), 64'(act_q[0][50:47]));
    check("second uop", 64'(op_add), 64'(act_q[1][50:47]));
    end_test();
  endtask

  task automatic test_illegal();
    int n;
    start_test("illegal");
    send(op_illegal, 1'b0);
    drain();
    check("illegal events", 64'(1), 64'(act_q.size()));
    @(posedge clk);
    send(op_add, 1'b1);                   // the pipe must still flow afterwards
    nm_send(op_mul);
    repeat (3) @(negedge clk);
    check("nomul illegal pulses", 64'(1), 64'(nm_ill_cnt));
    check("nomul transfers", 64'(0), 64'(nm_xfer_cnt));
    @(posedge clk);
    nm_send(op_add);
    n = 0;
    while (nm_xfer_cnt == 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    check("nomul add transfers", 64'(1), 64'(nm_xfer_cnt));
    check("nomul add uop", 64'(op_add), 64'(nm_last_uop));
    check("nomul pulses after add", 64'(1), 64'(nm_ill_cnt));
    end_test();
  endtask

  task automatic test_random();
    logic [31:0] w;
    rec_t        e;
    logic        acc;
    int          sent;
    int          n;
    start_test("random");
    sent = 0;
    n    = 0;
    while (sent < 200 && n < 4000) begin
      @(negedge clk);
      acc = in_val && in_rdy;             // the handshake of the coming edge
      @(posedge clk);
      n++;
      if (acc) sent++;
      ex_rdy <= 3'($random(seed));
      if (acc || !in_val) begin
        if (sent < 200 && ($random(seed) & 3) != 0) begin
          build(rv_uop'($unsigned($random(seed)) % 8), 1'($random(seed)), w, e);
          offer(w, e);
        end else begin
          in_val <= 1'b0;
        end
      end
    end
    if (sent < 200) begin
      $display("error in %s: only %0d of 200 words were accepted", cur_test, sent);
      err_cnt++;
    end
    ex_rdy <= 3'b111;
    end_test();
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    in_val      = 1'b0;
    in_inst     = '0;
    in_exp      = '0;
    ex_rdy      = '0;
    nm_in_val   = 1'b0;
    nm_in_inst  = '0;
    nm_ex_rdy   = 3'b111;
    nm_ill_cnt  = 0;
    nm_xfer_cnt = 0;
    err_cnt     = 0;
    test_cnt    = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_decode();
    test_fallback();
    test_backpressure();
    test_illegal();
    test_random();
    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(test_cycles * 4 * 10);
    $display("error: watchdog expired after %0d cycles, run did not finish", test_cycles * 4);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* sim.f */
verilog/rv_isa_pkg.sv
verilog/decode_cfg_pkg.sv
verilog/inst_decoder.sv
verilog/inst_router.sv
verilog/decode_unit.sv
tb/decode_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the decode stage testbench with verilator and runs it
# exits nonzero when a step fails or the log reports a failure

cd "$(dirname "$0")" || exit 1

obj=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f --top-module decode_unit_tb --Mdir "$obj" -o decode_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj/decode_unit_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

echo "simulation passed"
exit 0
